// File: hdl/memMapPkg.sv
package memMapPkg;

    localparam int dataWidth    = 32;
    localparam int ramDepth     = 256;
    localparam int ramAddrWidth = 8;   // RAM index comes from address bits 9 to 2.
    localparam int ledWidth     = 8;
    localparam int switchWidth  = 8;
    localparam int tubeWidth    = 18;

    localparam logic [tubeWidth-1:0] tubeResetValue = '1;   // All segments off.

    // Peripheral registers.
    localparam logic [dataWidth-1:0] timerThAddr  = 32'h4000_0000;
    localparam logic [dataWidth-1:0] timerTlAddr  = 32'h4000_0004;
    localparam logic [dataWidth-1:0] timerConAddr = 32'h4000_0008;
    localparam logic [dataWidth-1:0] ledAddr      = 32'h4000_000C;
    localparam logic [dataWidth-1:0] switchAddr   = 32'h4000_0010;
    localparam logic [dataWidth-1:0] tubeAddr     = 32'h4000_0014;

    // Byte addresses of the first and last display table word.
    localparam logic [dataWidth-1:0] tableBase = 32'd1024;
    localparam logic [dataWidth-1:0] tableLast = 32'd2044;

    localparam int segWidth = 7;

    localparam logic [segWidth-1:0] digitSegCodes [10] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66,
        7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F
    };

    // Table word that the bus reads flat and the table builds per digit.
    typedef union packed {
        logic [3*segWidth-1:0]        flat;
        logic [2:0][segWidth-1:0]     digit;   // 2 hundreds, 1 tens, 0 ones.
    } segTriple_u;

endpackage

// File: hdl/wordRam.sv
module wordRam (
    input  logic                                reset,
    input  logic                                clk,
    input  logic                                ramWrite,
    input  logic [memMapPkg::ramAddrWidth-1:0]  ramIndex,
    input  logic [memMapPkg::dataWidth-1:0]     writeData,
    output logic [memMapPkg::dataWidth-1:0]     ramWord
);

    logic [memMapPkg::dataWidth-1:0] mem [memMapPkg::ramDepth];

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < memMapPkg::ramDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (ramWrite) begin
            mem[ramIndex] <= writeData;
        end
    end

    assign ramWord = mem[ramIndex];   // Asynchronous read.

endmodule

// File: hdl/segmentTable.sv
module segmentTable (
    input  logic [memMapPkg::ramAddrWidth-1:0]  ramIndex,
    output memMapPkg::segTriple_u               segWord
);

    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;

    // Decimal split of the index, 0 to 255.
    always_comb begin
        hundreds = 4'(ramIndex / 8'd100);
        tens     = 4'((ramIndex / 8'd10) % 8'd10);
        ones     = 4'(ramIndex % 8'd10);
    end

    always_comb begin
        segWord.digit[2] = memMapPkg::digitSegCodes[hundreds];
        segWord.digit[1] = memMapPkg::digitSegCodes[tens];
        segWord.digit[0] = memMapPkg::digitSegCodes[ones];
    end

endmodule

// File: hdl/ioRegisters.sv
module ioRegisters (
    input  logic                                reset,
    input  logic                                clk,
    input  logic                                ledWrite,
    input  logic                                tubeWrite,
    input  logic [memMapPkg::dataWidth-1:0]     writeData,
    output logic [memMapPkg::ledWidth-1:0]      ledValue,
    output logic [memMapPkg::tubeWidth-1:0]     tubeValue
);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            ledValue <= '0;
        end else if (ledWrite) begin
            ledValue <= writeData[memMapPkg::ledWidth-1:0];
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            tubeValue <= memMapPkg::tubeResetValue;   // Display blank.
        end else if (tubeWrite) begin
            tubeValue <= writeData[memMapPkg::tubeWidth-1:0];
        end
    end

endmodule

// File: hdl/systemTimer.sv
module systemTimer (
    input  logic                                reset,
    input  logic                                clk,
    input  logic                                thWrite,
    input  logic                                conWrite,
    input  logic [memMapPkg::dataWidth-1:0]     writeData,
    output logic [memMapPkg::dataWidth-1:0]     tlValue,
    output logic [1:0]                          conValue,
    output logic                                overflowFlag
);

    logic [memMapPkg::dataWidth-1:0] thValue;   // Reload value.

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            thValue      <= '0;
            tlValue      <= '0;
            conValue     <= '0;
            overflowFlag <= 1'b0;
        end else begin
            if (conValue[0]) begin
                if (&tlValue) begin
                    tlValue <= thValue;   // Wrap to reload value.
                    if (conValue[1]) begin
                        overflowFlag <= 1'b1;
                    end
                end else begin
                    tlValue <= tlValue + 1;
                end
            end
            // Bus writes take priority over counting.
            if (thWrite) begin
                thValue <= writeData;
                tlValue <= writeData;
            end
            if (conWrite) begin
                conValue     <= writeData[1:0];
                overflowFlag <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/busDecoder.sv
module busDecoder (
    input  logic                                readEnable,
    input  logic                                writeEnable,
    input  logic [memMapPkg::dataWidth-1:0]     address,
    input  logic [memMapPkg::switchWidth-1:0]   switch,
    input  logic [memMapPkg::dataWidth-1:0]     ramWord,
    input  memMapPkg::segTriple_u               segWord,
    input  logic [memMapPkg::ledWidth-1:0]      ledValue,
    input  logic [memMapPkg::tubeWidth-1:0]     tubeValue,
    input  logic [memMapPkg::dataWidth-1:0]     tlValue,
    input  logic [1:0]                          conValue,
    input  logic                                overflowFlag,
    output logic                                ramWrite,
    output logic                                ledWrite,
    output logic                                tubeWrite,
    output logic                                thWrite,
    output logic                                conWrite,
    output logic [memMapPkg::ramAddrWidth-1:0]  ramIndex,
    output logic [memMapPkg::dataWidth-1:0]     readData
);

    logic inTable;

    assign inTable  = (address >= memMapPkg::tableBase) && (address <= memMapPkg::tableLast);
    assign ramIndex = address[memMapPkg::ramAddrWidth+1:2];   // Word index for RAM and table.

    always_comb begin
        ramWrite  = 1'b0;
        ledWrite  = 1'b0;
        tubeWrite = 1'b0;
        thWrite   = 1'b0;
        conWrite  = 1'b0;
        if (writeEnable) begin
            case (address)
                memMapPkg::timerThAddr:  thWrite   = 1'b1;
                memMapPkg::timerConAddr: conWrite  = 1'b1;
                memMapPkg::ledAddr:      ledWrite  = 1'b1;
                memMapPkg::tubeAddr:     tubeWrite = 1'b1;
                memMapPkg::timerTlAddr,
                memMapPkg::switchAddr:   ;           // Read-only registers.
                default:                 ramWrite = !inTable;
            endcase
        end
    end

    always_comb begin
        readData = '0;
        if (readEnable) begin
            case (address)
                memMapPkg::timerThAddr:  ;           // TH is write-only.
                memMapPkg::timerTlAddr:  readData = tlValue;
                memMapPkg::timerConAddr: readData[2:0] = {overflowFlag, conValue};
                memMapPkg::ledAddr:      readData[memMapPkg::ledWidth-1:0] = ledValue;
                memMapPkg::switchAddr:   readData[memMapPkg::switchWidth-1:0] = switch;
                memMapPkg::tubeAddr:     readData[memMapPkg::tubeWidth-1:0] = tubeValue;
                default: begin
                    if (inTable) begin
                        readData[$bits(memMapPkg::segTriple_u)-1:0] = segWord.flat;
                    end else begin
                        readData = ramWord;
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/dataMemory.sv
module dataMemory (
    input  logic                                reset,
    input  logic                                clk,
    input  logic                                readEnable,
    input  logic                                writeEnable,
    input  logic [memMapPkg::dataWidth-1:0]     address,
    input  logic [memMapPkg::dataWidth-1:0]     writeData,
    input  logic [memMapPkg::switchWidth-1:0]   switch,
    output logic [memMapPkg::dataWidth-1:0]     readData,
    output logic [memMapPkg::ledWidth-1:0]      led,
    output logic [memMapPkg::tubeWidth-1:0]     tube,
    output logic                                ifContinue
);

    logic                                ramWrite;
    logic                                ledWrite;
    logic                                tubeWrite;
    logic                                thWrite;
    logic                                conWrite;
    logic [memMapPkg::ramAddrWidth-1:0]  ramIndex;
    logic [memMapPkg::dataWidth-1:0]     ramWord;
    memMapPkg::segTriple_u               segWord;
    logic [memMapPkg::dataWidth-1:0]     tlValue;
    logic [1:0]                          conValue;

    busDecoder i_busDecoder (
        .readEnable   (readEnable),
        .writeEnable  (writeEnable),
        .address      (address),
        .switch       (switch),
        .ramWord      (ramWord),
        .segWord      (segWord),
        .ledValue     (led),
        .tubeValue    (tube),
        .tlValue      (tlValue),
        .conValue     (conValue),
        .overflowFlag (ifContinue),
        .ramWrite     (ramWrite),
        .ledWrite     (ledWrite),
        .tubeWrite    (tubeWrite),
        .thWrite      (thWrite),
        .conWrite     (conWrite),
        .ramIndex     (ramIndex),
        .readData     (readData)
    );

    wordRam i_wordRam (
        .reset     (reset),
        .clk       (clk),
        .ramWrite  (ramWrite),
        .ramIndex  (ramIndex),
        .writeData (writeData),
        .ramWord   (ramWord)
    );

    segmentTable i_segmentTable (
        .ramIndex (ramIndex),
        .segWord  (segWord)
    );

    ioRegisters i_ioRegisters (
        .reset     (reset),
        .clk       (clk),
        .ledWrite  (ledWrite),
        .tubeWrite (tubeWrite),
        .writeData (writeData),
        .ledValue  (led),
        .tubeValue (tube)
    );

    systemTimer i_systemTimer (
        .reset        (reset),
        .clk          (clk),
        .thWrite      (thWrite),
        .conWrite     (conWrite),
        .writeData    (writeData),
        .tlValue      (tlValue),
        .conValue     (conValue),
        .overflowFlag (ifContinue)
    );

endmodule

// File: tb/clockGen.sv
module clockGen (
    output logic reset,   // Clock.
    output logic clk      // Asynchronous reset, active high.
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        reset = 1'b0;
        clk   = 1'b1;
        repeat (3) begin
            @(posedge reset);
        end
        #1 clk = 1'b0;   // Release just after the third edge.
    end

    always #5 reset = ~reset;   // 10 ns period.

endmodule

// File: tb/dataMemory_asserts.sv
module dataMemoryAsserts (
    input logic        reset,
    input logic        clk,
    input logic        readEnable,
    input logic        writeEnable,
    input logic [31:0] address,
    input logic [31:0] writeData,
    input logic [7:0]  switch,
    input logic [31:0] readData,
    input logic [7:0]  led,
    input logic [17:0] tube,
    input logic        ifContinue,
    input logic [31:0] tlValue
);
    timeunit 1ns;
    timeprecision 1ps;

    int          failCount = 0;
    logic [31:0] ramShadow [256];
    logic [7:0]  ledShadow;
    logic [17:0] tubeShadow;
    logic [1:0]  conShadow;
    logic [31:0] regReadExp;
    logic        isPeriph;
    logic        inTable;
    logic        timerArmed;

    function automatic logic [6:0] segOf(input int d);
        case (d)
            0: return 7'h3F;
            1: return 7'h06;
            2: return 7'h5B;
            3: return 7'h4F;
            4: return 7'h66;
            5: return 7'h6D;
            6: return 7'h7D;
            7: return 7'h07;
            8: return 7'h7F;
            9: return 7'h6F;
            default: return 7'h00;
        endcase
    endfunction

    function automatic logic [31:0] tableWordOf(input logic [7:0] n);
        int value;
        value = int'(n);
        return {11'd0, segOf(value / 100), segOf(value / 10 % 10), segOf(value % 10)};
    endfunction

    assign isPeriph = address inside {memMapPkg::timerThAddr, memMapPkg::timerTlAddr,
        memMapPkg::timerConAddr, memMapPkg::ledAddr, memMapPkg::switchAddr, memMapPkg::tubeAddr};
    assign inTable = (address >= 32'd1024) && (address <= 32'd2044);

    // CON set to 3 while stopped with TL at all ones minus 5.
    assign timerArmed = writeEnable && (address == memMapPkg::timerConAddr)
        && (writeData[1:0] == 2'b11) && !conShadow[0] && (tlValue == 32'hFFFF_FFFA);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            ledShadow  <= '0;
            tubeShadow <= '1;
            conShadow  <= '0;
            for (int i = 0; i < 256; i++) begin
                ramShadow[i] <= '0;
            end
        end else if (writeEnable) begin
            case (address)
                memMapPkg::ledAddr:      ledShadow  <= writeData[7:0];
                memMapPkg::tubeAddr:     tubeShadow <= writeData[17:0];
                memMapPkg::timerConAddr: conShadow  <= writeData[1:0];
                default: begin
                    if (!isPeriph && !inTable) begin
                        ramShadow[address[9:2]] <= writeData;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (address)
            memMapPkg::timerTlAddr:  regReadExp = tlValue;
            memMapPkg::timerConAddr: regReadExp = {29'd0, ifContinue, conShadow};
            memMapPkg::ledAddr:      regReadExp = {24'd0, ledShadow};
            memMapPkg::switchAddr:   regReadExp = {24'd0, switch};
            memMapPkg::tubeAddr:     regReadExp = {14'd0, tubeShadow};
            default:                 regReadExp = '0;
        endcase
    end

    assert property (@(posedge reset) $fell(clk) |-> led == '0 && tube == '1 && !ifContinue)
    else begin
        failCount++;
        $error("ERR %0t led exp 00 got %h, tube exp 3ffff got %h, ifContinue exp 0 got %b",
            $time, $sampled(led), $sampled(tube), $sampled(ifContinue));
    end

    assert property (@(posedge reset) disable iff (clk) !readEnable |-> readData == '0)
    else begin
        failCount++;
        $error("ERR %0t readData exp 00000000 got %h", $time, $sampled(readData));
    end

    assert property (@(posedge reset) disable iff (clk)
        readEnable && inTable |-> readData == tableWordOf(address[9:2]))
    else begin
        failCount++;
        $error("ERR %0t readData exp %h got %h", $time,
            tableWordOf($sampled(address[9:2])), $sampled(readData));
    end

    assert property (@(posedge reset) disable iff (clk)
        readEnable && !inTable && !isPeriph |-> readData == ramShadow[address[9:2]])
    else begin
        failCount++;
        $error("ERR %0t readData exp %h got %h", $time,
            ramShadow[$sampled(address[9:2])], $sampled(readData));
    end

    assert property (@(posedge reset) disable iff (clk)
        readEnable && isPeriph |-> readData == regReadExp)
    else begin
        failCount++;
        $error("ERR %0t readData exp %h got %h", $time, $sampled(regReadExp), $sampled(readData));
    end

    assert property (@(posedge reset) disable iff (clk) led == ledShadow && tube == tubeShadow)
    else begin
        failCount++;
        $error("ERR %0t led exp %h got %h, tube exp %h got %h", $time, $sampled(ledShadow),
            $sampled(led), $sampled(tubeShadow), $sampled(tube));
    end

    assert property (@(posedge reset) disable iff (clk) $past(timerArmed, 7) |-> $rose(ifContinue))
    else begin
        failCount++;
        $error("ifContinue did not rise exactly 6 edges after the timer was started");
    end

    assert property (@(posedge reset) disable iff (clk)
        writeEnable && address == memMapPkg::timerConAddr |=> !ifContinue)
    else begin
        failCount++;
        $error("ERR %0t ifContinue exp 0 got %b", $time, $sampled(ifContinue));
    end

    // TL holds while counting is off and TH is not written.
    assert property (@(posedge reset) disable iff (clk)
        !conShadow[0] && !(writeEnable && address == memMapPkg::timerThAddr) |=> $stable(tlValue))
    else begin
        failCount++;
        $error("ERR %0t tlValue exp %h got %h", $time, $past(tlValue), $sampled(tlValue));
    end

endmodule

bind dataMemory dataMemoryAsserts i_asserts (.*);

// File: tb/dataMemory_tb.sv
module dataMemory_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cycleLimit = 1500;
    localparam int flagWait   = 20;

    logic                               reset;   // Clock.
    logic                               clk;     // Asynchronous reset.
    logic                               readEnable;
    logic                               writeEnable;
    logic [memMapPkg::dataWidth-1:0]    address;
    logic [memMapPkg::dataWidth-1:0]    writeData;
    logic [memMapPkg::switchWidth-1:0]  switch;
    logic [memMapPkg::dataWidth-1:0]    readData;
    logic [memMapPkg::ledWidth-1:0]     led;
    logic [memMapPkg::tubeWidth-1:0]    tube;
    logic                               ifContinue;
    int                                 cycles = 0;
    int                                 waitFails = 0;

    clockGen i_clockGen (
        .reset (reset),
        .clk   (clk)
    );

    dataMemory i_dut (
        .reset       (reset),
        .clk         (clk),
        .readEnable  (readEnable),
        .writeEnable (writeEnable),
        .address     (address),
        .writeData   (writeData),
        .switch      (switch),
        .readData    (readData),
        .led         (led),
        .tube        (tube),
        .ifContinue  (ifContinue)
    );

    task automatic stepCycle();
        @(posedge reset);
        #1;   // Drive just after the edge.
    endtask

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        address     = addr;
        writeData   = data;
        writeEnable = 1'b1;
        stepCycle();
        writeEnable = 1'b0;
    endtask

    task automatic readWord(input logic [31:0] addr);
        address    = addr;
        readEnable = 1'b1;
        stepCycle();
        readEnable = 1'b0;
    endtask

    task automatic waitForFlag();
        int n;
        n = 0;
        while (!ifContinue && n < flagWait) begin
            stepCycle();
            n++;
        end
        if (!ifContinue) begin
            waitFails++;
            $display("Timer flag did not rise within %0d cycles", flagWait);
        end
    endtask

    task automatic finishRun(input bit timedOut);
        int fails;
        fails = i_dut.i_asserts.failCount;
        if (timedOut) begin
            $display("Run stopped at the %0d-cycle limit before the tests completed", cycleLimit);
        end
        $display("Assertion failures: %0d, wait failures: %0d, timeouts: %0d",
            fails, waitFails, int'(timedOut));
        if (fails == 0 && waitFails == 0 && !timedOut) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    always @(posedge reset) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            finishRun(1'b1);
        end
    end

    initial begin : stimulus
        logic [31:0] ramAddrs [30];
        logic [7:0]  idx;
        readEnable  = 1'b0;
        writeEnable = 1'b0;
        address     = '0;
        writeData   = '0;
        switch      = 8'h5A;
        void'($urandom(26396));
        @(negedge clk);
        stepCycle();
        stepCycle();
        repeat (40) begin
            idx = 8'($urandom_range(255));
            readWord(memMapPkg::tableBase + {22'd0, idx, 2'b00});
        end
        foreach (ramAddrs[i]) begin
            ramAddrs[i] = {22'd0, 8'($urandom_range(255)), 2'b00};
            writeWord(ramAddrs[i], $urandom());
        end
        foreach (ramAddrs[i]) begin
            readWord(ramAddrs[i]);
        end
        repeat (4) begin
            writeWord(memMapPkg::ledAddr, $urandom());
            readWord(memMapPkg::ledAddr);
            writeWord(memMapPkg::tubeAddr, $urandom());
            readWord(memMapPkg::tubeAddr);
            switch = 8'($urandom());
            readWord(memMapPkg::switchAddr);
        end
        writeWord(memMapPkg::timerConAddr, 32'd0);
        writeWord(memMapPkg::timerThAddr, 32'hFFFF_FFFA);   // All ones minus 5.
        writeWord(memMapPkg::timerConAddr, 32'd3);
        waitForFlag();
        readWord(memMapPkg::timerConAddr);
        writeWord(memMapPkg::timerConAddr, 32'd0);
        repeat (3) begin
            readWord(memMapPkg::timerTlAddr);
        end
        stepCycle();
        stepCycle();
        finishRun(1'b0);
    end

endmodule

// File: project.f
hdl/memMapPkg.sv
hdl/wordRam.sv
hdl/segmentTable.sv
hdl/ioRegisters.sv
hdl/systemTimer.sv
hdl/busDecoder.sv
hdl/dataMemory.sv
tb/clockGen.sv
tb/dataMemory_asserts.sv
tb/dataMemory_tb.sv

// File: Makefile
SIM := obj_dir/VdataMemory_tb

$(SIM): project.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --assert --timing --top-module dataMemory_tb -f project.f

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

.PHONY: run clean
